/* bench/jal_unit_chk.sv */
// jump unit checker: concurrent rules on dispatch, issue, pending marks and flush

module jal_unit_chk #(
	parameter int DP = 4
) (
	input  logic                 CLK,
	input  logic                 arst_n,
	input  logic                 flush,
	input  logic                 dsp_valid,
	input  logic                 dsp_full,
	input  logic [DP-1:0]        slot_pop,
	input  logic                 mark_valid,
	input  core_pkg::reg_idx_t   mark_rd,
	input  core_pkg::reg_vec_t   pending,
	input  logic                 res_valid,
	input  jal_pkg::jal_res_t    res
);

	int fails = 0;   // read by the testbench at the end

	a_no_dsp_when_full: assert property (@(posedge CLK) disable iff (!arst_n)
		!(dsp_valid && dsp_full))
		else begin
			$error("dispatch strobe while every slot is busy");
			fails++;
		end

	a_pop_onehot: assert property (@(posedge CLK) disable iff (!arst_n)
		$onehot0(slot_pop))
		else begin
			$error("more than one slot popped in one cycle");
			fails++;
		end

	// a write-back in the same cycle frees the register
	a_mark_free: assert property (@(posedge CLK) disable iff (!arst_n)
		mark_valid |-> !pending[mark_rd] || (res_valid && res.rd == mark_rd))
		else begin
			$error("rd marked while it already has a pending writer");
			fails++;
		end

	a_flush_kills_res: assert property (@(posedge CLK) disable iff (!arst_n)
		flush |=> !res_valid)
		else begin
			$error("result strobe in the cycle after flush");
			fails++;
		end

endmodule

bind jal_unit jal_unit_chk #(.DP(DP)) jal_unit_chk_inst (.*);

/* bench/jal_unit_tb.sv */
// jump unit testbench driving random jumps against a program-order register model

module jal_unit_tb;

	import core_pkg::*;
	import jal_pkg::*;

	localparam int DP         = 4;
	localparam int N_DISPATCH = 72;   // all tests, flush strobe included
	localparam int TIMEOUT    = 40 * 10 * N_DISPATCH;

	logic      CLK;
	logic      arst_n;
	logic      flush;
	logic      dsp_valid;
	jal_info_t dsp_info;
	logic      dsp_full;
	logic      res_valid;
	jal_res_t  res;

	logic [15:0] lfsr;
	tag_t        next_tag;
	xlen_t       spec_regs [32];   // program order
	xlen_t       committed [32];   // as results arrive
	jal_res_t    exp_res [16];
	logic        exp_valid [16];
	reg_idx_t    exp_rs1 [16];
	int          wr_issued [32];
	int          wr_done [32];
	int          rd_issued [32];
	int          rd_done [32];
	int          errors;
	int          test_errs;
	int          n_sent;
	int          n_checked;
	int          n_flushed;
	logic        full_seen;

	jal_unit #(.DP(DP)) jal_unit_inst (
		.CLK(CLK), .arst_n(arst_n), .flush(flush), .dsp_valid(dsp_valid),
		.dsp_info(dsp_info), .dsp_full(dsp_full), .res_valid(res_valid), .res(res)
	);

	always #5 CLK = ~CLK;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [63:0] draw(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[62:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic jal_res_t expect_result(input jal_info_t i, input xlen_t src1);
		jal_res_t r;
		r.tag  = i.tag;
		r.rd   = i.rd;
		r.link = i.rvc ? i.pc + 64'd2 : i.pc + 64'd4;
		if (i.op == op_jal) begin
			r.target = i.pc + i.imm;
		end else begin
			r.target    = src1 + i.imm;
			r.target[0] = 1'b0;
		end
		return r;
	endfunction

	// still written or read by a jump in flight
	function automatic logic reg_in_use(input reg_idx_t r);
		return (wr_issued[r] != wr_done[r]) || (rd_issued[r] != rd_done[r]);
	endfunction

	function automatic int outstanding();
		int n;
		n = 0;
		for (int t = 0; t < 16; t++)
			n += exp_valid[t];
		return n;
	endfunction

	// op_sel 0 jal, 1 jalr, -1 random; rd_sel and rs1_sel -1 random
	task automatic send(input int op_sel, input int rd_sel, input int rs1_sel);
		jal_info_t   info;
		logic [63:0] b;
		xlen_t       src1;
		b = draw(1);
		if (op_sel < 0)
			info.op = b[0] ? op_jalr : op_jal;
		else
			info.op = (op_sel == 1) ? op_jalr : op_jal;
		info.tag = next_tag;
		info.pc  = draw(64);
		if (info.op == op_jal) begin
			b = draw(20);
			info.imm = {{43{b[19]}}, b[19:0], 1'b0};
		end else begin
			b = draw(12);
			info.imm = {{52{b[11]}}, b[11:0]};
		end
		b = draw(1);
		info.rvc = b[0];
		b = draw(3);
		info.rd = (rd_sel < 0) ? reg_idx_t'(b[2:0]) : reg_idx_t'(rd_sel);
		b = draw(3);
		info.rs1 = (rs1_sel < 0) ? reg_idx_t'(b[2:0]) : reg_idx_t'(rs1_sel);
		if (info.rd != '0 && (reg_in_use(info.rd) ||
				(info.op == op_jalr && info.rs1 == info.rd)))
			info.rd = '0;   // ordering rule
		while (dsp_full) begin
			full_seen = 1'b1;
			@(negedge CLK);
		end
		src1 = (info.op == op_jalr) ? spec_regs[info.rs1] : '0;
		exp_res[info.tag]   = expect_result(info, src1);
		exp_valid[info.tag] = 1'b1;
		exp_rs1[info.tag]   = (info.op == op_jalr) ? info.rs1 : '0;
		if (info.rd != '0) begin
			spec_regs[info.rd] = exp_res[info.tag].link;
			wr_issued[info.rd]++;
		end
		if (info.op == op_jalr && info.rs1 != '0)
			rd_issued[info.rs1]++;
		dsp_info  = info;
		dsp_valid = 1'b1;
		next_tag++;
		n_sent++;
		@(negedge CLK);
		dsp_valid = 1'b0;
	endtask

	task automatic flush_all();
		jal_info_t   junk;
		logic [63:0] b;
		b = draw(64);
		junk     = '0;
		junk.tag = next_tag;
		junk.pc  = b;
		junk.rd  = reg_idx_t'(b[2:0]);
		flush     = 1'b1;
		dsp_info  = junk;
		dsp_valid = !dsp_full;   // slot write is lost under flush
		next_tag++;
		@(posedge CLK);
		// results seen before this edge are committed, the rest are gone
		for (int t = 0; t < 16; t++) begin
			if (exp_valid[t])
				n_flushed++;
			exp_valid[t] = 1'b0;
		end
		for (int r = 0; r < 32; r++) begin
			spec_regs[r] = committed[r];
			wr_issued[r] = wr_done[r];
			rd_issued[r] = rd_done[r];
		end
		@(negedge CLK);
		flush     = 1'b0;
		dsp_valid = 1'b0;
	endtask

	task automatic drain();
		while (outstanding() != 0)
			@(negedge CLK);
	endtask

	task automatic close_test(input string name);
		drain();
		$display("%s: %0d errors", name, errors - test_errs);
		test_errs = errors;
	endtask

	always @(negedge CLK) begin : compare_results
		tag_t t;
		if (arst_n && res_valid) begin
			t = res.tag;
			n_checked++;
			assert (exp_valid[t]) else begin
				$display("result with tag %0d arrived but no such jump is in flight", t);
				errors++;
			end
			if (exp_valid[t]) begin
				assert (res === exp_res[t]) else begin
					$display("** Error at time %0t: tag %0d rd %0d link %h target %h",
						$time, t, res.rd, res.link, res.target);
					$display("   expected rd %0d link %h target %h",
						exp_res[t].rd, exp_res[t].link, exp_res[t].target);
					errors++;
				end
				exp_valid[t] <= 1'b0;
				if (exp_res[t].rd != '0) begin
					committed[exp_res[t].rd] <= exp_res[t].link;
					wr_done[exp_res[t].rd]   <= wr_done[exp_res[t].rd] + 1;
				end
				if (exp_rs1[t] != '0)
					rd_done[exp_rs1[t]] <= rd_done[exp_rs1[t]] + 1;
			end
		end
	end

	initial begin
		#(TIMEOUT);
		$display("timeout after %0d time units, results stopped arriving", TIMEOUT);
		$display("test failed");
		$finish;
	end

	initial begin : main
		logic [63:0] b;
		int          r;
		CLK       = 1'b0;
		arst_n    = 1'b0;
		flush     = 1'b0;
		dsp_valid = 1'b0;
		dsp_info  = '0;
		lfsr      = 16'd64171;
		next_tag  = '0;
		errors    = 0;
		test_errs = 0;
		n_sent    = 0;
		n_checked = 0;
		n_flushed = 0;
		full_seen = 1'b0;
		for (int i = 0; i < 32; i++) begin
			spec_regs[i] = '0;
			committed[i] = '0;
			wr_issued[i] = 0;
			wr_done[i]   = 0;
			rd_issued[i] = 0;
			rd_done[i]   = 0;
		end
		for (int t = 0; t < 16; t++)
			exp_valid[t] = 1'b0;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		arst_n = 1'b1;

		repeat (12) send(0, -1, -1);
		close_test("jal alone");

		repeat (10) begin
			send(1, -1, -1);
			drain();   // source settled before the next one
		end
		close_test("jalr on settled source");

		repeat (6) begin
			b = draw(3);
			r = int'(b[2:0]) % 7 + 1;
			send(0, r, -1);
			send(1, -1, r);
			send(0, -1, -1);
			send(0, -1, -1);
			drain();
		end
		close_test("jalr on jal in flight");

		full_seen = 1'b0;
		send(0, 1, -1);
		for (int k = 2; k < 8; k++)
			send(1, k, k - 1);   // chain x1 to x7
		assert (full_seen) else begin
			$display("dsp_full never rose while a chain of dependent jalr waited");
			errors++;
		end
		close_test("fill to full");

		repeat (4) send(-1, -1, -1);
		flush_all();
		repeat (8) send(-1, -1, -1);
		close_test("flush");

		repeat (3) begin
			send(0, 0, -1);
			send(1, -1, 0);
		end
		close_test("writes to x0");

		errors += jal_unit_inst.jal_unit_chk_inst.fails;
		$display("%0d dispatched, %0d results checked, %0d flushed, %0d errors",
			n_sent, n_checked, n_flushed, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* design/core_pkg.sv */
// core package: word width and architectural register types

package core_pkg;

	parameter int XLEN = 64;
	parameter int NREG = 32;

	// one data word
	typedef logic [XLEN-1:0] xlen_t;

	// architectural register index, x0 to x31
	typedef logic [$clog2(NREG)-1:0] reg_idx_t;

	// one bit per register
	typedef logic [NREG-1:0] reg_vec_t;

endpackage

/* design/jal_dispatch.sv */
// jump dispatch: places each incoming jump in the lowest free slot and marks rd pending

module jal_dispatch #(
	parameter int DP = 4
) (
	input  logic                 flush,
	input  logic                 dsp_valid,
	input  jal_pkg::jal_info_t   dsp_info,
	input  logic [DP-1:0]        slot_busy,
	output logic                 dsp_full,
	output logic [DP-1:0]        slot_write,
	output jal_pkg::jal_info_t   slot_info,
	output logic                 mark_valid,
	output core_pkg::reg_idx_t   mark_rd
);

	localparam int IW = $clog2(DP);

	logic [IW-1:0] free_idx;
	logic          accept;

	// lowest free slot wins
	always_comb begin
		free_idx = '0;
		for (int i = DP - 1; i >= 0; i--) begin
			if (!slot_busy[i])
				free_idx = IW'(i);
		end
	end

	assign dsp_full = &slot_busy;

	// a write in the flush cycle is lost
	assign accept = dsp_valid & ~dsp_full & ~flush;

	always_comb begin
		slot_write = '0;
		if (accept)
			slot_write[free_idx] = 1'b1;
	end

	assign slot_info  = dsp_info;   // shared by all slots
	assign mark_rd    = dsp_info.rd;
	assign mark_valid = accept & (dsp_info.rd != '0);   // x0 never pending

endmodule

/* design/jal_execute.sv */
// jump execute: computes link and target and registers the result

module jal_execute (
	input  logic                 CLK,
	input  logic                 arst_n,
	input  logic                 flush,
	input  logic                 exe_valid,
	input  jal_pkg::jal_exe_t    exe,
	output logic                 res_valid,
	output jal_pkg::jal_res_t    res
);

	import core_pkg::*;
	import jal_pkg::*;

	xlen_t link;
	xlen_t target;

	assign link = exe.pc + (exe.rvc ? XLEN'(2) : XLEN'(4));

	always_comb begin
		if (exe.op == op_jal)
			target = exe.pc + exe.imm;
		else
			target = (exe.src1 + exe.imm) & ~XLEN'(1);   // jalr drops bit 0
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n)
			res_valid <= 1'b0;
		else
			res_valid <= exe_valid & ~flush;
	end

	always_ff @(posedge CLK) begin
		if (exe_valid) begin
			res.tag    <= exe.tag;
			res.rd     <= exe.rd;
			res.link   <= link;
			res.target <= target;
		end
	end

endmodule

/* design/jal_issue.sv */
// jump issue: picks the first ready slot, reads rs1 and registers the execute parameter

module jal_issue #(
	parameter int DP = 4
) (
	input  logic                 CLK,
	input  logic                 arst_n,
	input  logic                 flush,
	input  logic [DP-1:0]        slot_ready,
	input  jal_pkg::jal_info_t   slot_info [DP],
	input  core_pkg::xlen_t      rd_data,
	output logic [DP-1:0]        slot_pop,
	output core_pkg::reg_idx_t   rd_idx,
	output logic                 exe_valid,
	output jal_pkg::jal_exe_t    exe
);

	import jal_pkg::*;

	localparam int IW = $clog2(DP);

	logic [IW-1:0] sel;
	logic          any_ready;
	logic          issue;
	jal_info_t     pick;

	// leading-one search, lowest index first
	always_comb begin
		sel = '0;
		for (int i = DP - 1; i >= 0; i--) begin
			if (slot_ready[i])
				sel = IW'(i);
		end
	end

	assign any_ready = |slot_ready;
	assign issue     = any_ready & ~flush;   // execute is always ready
	assign pick      = slot_info[sel];
	assign rd_idx    = pick.rs1;

	always_comb begin
		slot_pop = '0;
		if (issue)
			slot_pop[sel] = 1'b1;
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n)
			exe_valid <= 1'b0;
		else
			exe_valid <= issue;
	end

	// parameter holds when nothing issues
	always_ff @(posedge CLK) begin
		if (issue) begin
			exe.op   <= pick.op;
			exe.tag  <= pick.tag;
			exe.rd   <= pick.rd;
			exe.src1 <= rd_data;
			exe.pc   <= pick.pc;
			exe.imm  <= pick.imm;
			exe.rvc  <= pick.rvc;
		end
	end

endmodule

/* design/jal_pkg.sv */
// jump package: opcode and the payloads passed along the jump-and-link path

package jal_pkg;

	typedef enum logic {
		op_jal  = 1'b0,
		op_jalr = 1'b1
	} jal_op_e;

	typedef logic [3:0] tag_t;

	typedef struct packed {
		jal_op_e           op;
		tag_t              tag;
		core_pkg::xlen_t   pc;
		core_pkg::reg_idx_t rd;
		core_pkg::reg_idx_t rs1;
		core_pkg::xlen_t   imm;
		logic              rvc;   // compressed encoding, link is pc+2
	} jal_info_t;

	// execute parameter, rs1 already read
	typedef struct packed {
		jal_op_e           op;
		tag_t              tag;
		core_pkg::reg_idx_t rd;
		core_pkg::xlen_t   src1;
		core_pkg::xlen_t   pc;
		core_pkg::xlen_t   imm;
		logic              rvc;
	} jal_exe_t;

	typedef struct packed {
		tag_t              tag;
		core_pkg::reg_idx_t rd;
		core_pkg::xlen_t   link;
		core_pkg::xlen_t   target;
	} jal_res_t;

endpackage

/* design/jal_slot.sv */
// jump issue slot: holds one dispatched jump and reports when its operand is ready

module jal_slot (
	input  logic                 CLK,
	input  logic                 arst_n,
	input  logic                 flush,
	input  logic                 write,
	input  jal_pkg::jal_info_t   write_info,
	input  logic                 pop,
	input  core_pkg::reg_vec_t   pending,
	output logic                 busy,
	output logic                 ready,
	output jal_pkg::jal_info_t   info
);

	import jal_pkg::*;

	logic rs1_ok;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
		end else if (flush) begin
			busy <= 1'b0;
		end else if (write) begin
			busy <= 1'b1;
		end else if (pop) begin
			busy <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (write)
			info <= write_info;
	end

	// x0 is never written so never waits
	assign rs1_ok = (info.rs1 == '0) | ~pending[info.rs1];

	always_comb begin
		ready = 1'b0;
		if (busy) begin
			if (info.op == op_jal)
				ready = 1'b1;   // no source operand
			else
				ready = rs1_ok;
		end
	end

endmodule

/* design/jal_unit.sv */
// jump-and-link unit: dispatch, issue slots, issue, execute and register file

module jal_unit #(
	parameter int DP = 4
) (
	input  logic                 CLK,
	input  logic                 arst_n,
	input  logic                 flush,
	input  logic                 dsp_valid,
	input  jal_pkg::jal_info_t   dsp_info,
	output logic                 dsp_full,
	output logic                 res_valid,
	output jal_pkg::jal_res_t    res
);

	import core_pkg::*;
	import jal_pkg::*;

	logic [DP-1:0] slot_busy;
	logic [DP-1:0] slot_write;
	logic [DP-1:0] slot_ready;
	logic [DP-1:0] slot_pop;
	jal_info_t     slot_wr_info;
	jal_info_t     slot_q [DP];
	logic          mark_valid;
	reg_idx_t      mark_rd;
	reg_vec_t      pending;
	reg_idx_t      rd_idx;
	xlen_t         rd_data;
	logic          exe_valid;
	jal_exe_t      exe;

	jal_dispatch #(.DP(DP)) jal_dispatch_inst (
		.flush(flush), .dsp_valid(dsp_valid), .dsp_info(dsp_info),
		.slot_busy(slot_busy), .dsp_full(dsp_full), .slot_write(slot_write),
		.slot_info(slot_wr_info), .mark_valid(mark_valid), .mark_rd(mark_rd)
	);

	for (genvar i = 0; i < DP; i++) begin : g_slot
		jal_slot jal_slot_inst (
			.CLK(CLK), .arst_n(arst_n), .flush(flush),
			.write(slot_write[i]), .write_info(slot_wr_info), .pop(slot_pop[i]),
			.pending(pending), .busy(slot_busy[i]), .ready(slot_ready[i]),
			.info(slot_q[i])
		);
	end

	jal_issue #(.DP(DP)) jal_issue_inst (
		.CLK(CLK), .arst_n(arst_n), .flush(flush),
		.slot_ready(slot_ready), .slot_info(slot_q), .rd_data(rd_data),
		.slot_pop(slot_pop), .rd_idx(rd_idx), .exe_valid(exe_valid), .exe(exe)
	);

	jal_execute jal_execute_inst (
		.CLK(CLK), .arst_n(arst_n), .flush(flush),
		.exe_valid(exe_valid), .exe(exe), .res_valid(res_valid), .res(res)
	);

	// result doubles as write-back
	reg_file reg_file_inst (
		.CLK(CLK), .arst_n(arst_n), .flush(flush),
		.mark_valid(mark_valid), .mark_rd(mark_rd),
		.wb_valid(res_valid), .wb_rd(res.rd), .wb_data(res.link),
		.rd_idx(rd_idx), .rd_data(rd_data), .pending(pending)
	);

endmodule

/* design/reg_file.sv */
// integer register file with one pending bit per register as write-back log

module reg_file (
	input  logic                 CLK,
	input  logic                 arst_n,
	input  logic                 flush,
	input  logic                 mark_valid,
	input  core_pkg::reg_idx_t   mark_rd,
	input  logic                 wb_valid,
	input  core_pkg::reg_idx_t   wb_rd,
	input  core_pkg::xlen_t      wb_data,
	input  core_pkg::reg_idx_t   rd_idx,
	output core_pkg::xlen_t      rd_data,
	output core_pkg::reg_vec_t   pending
);

	import core_pkg::*;

	xlen_t regs [1:NREG-1];   // x0 has no storage
	logic  wb_en;

	assign wb_en = wb_valid & (wb_rd != '0);

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < NREG; i++)
				regs[i] <= '0;
		end else if (wb_en) begin
			regs[wb_rd] <= wb_data;
		end
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			pending <= '0;
		end else if (flush) begin
			pending <= '0;
		end else begin
			if (wb_en)
				pending[wb_rd] <= 1'b0;
			if (mark_valid && mark_rd != '0)
				pending[mark_rd] <= 1'b1;   // new writer wins over old write-back
		end
	end

	assign rd_data = (rd_idx == '0) ? '0 : regs[rd_idx];

endmodule

/* filelist.f */
design/core_pkg.sv
design/jal_pkg.sv
design/jal_dispatch.sv
design/jal_slot.sv
design/jal_issue.sv
design/jal_execute.sv
design/reg_file.sv
design/jal_unit.sv
bench/jal_unit_chk.sv
bench/jal_unit_tb.sv
